//--- lsu_load_cfg.svh
// --------------------------------------
// Load pipe configuration
// Address width, doubleword bytes and
// destination tag width
// --------------------------------------

`ifndef LSU_LOAD_CFG_SVH
`define LSU_LOAD_CFG_SVH

// Physical address width
// (no translation in this pipe)
`define LSU_VADDR_W 32

// Bytes in one doubleword, which is also the
// width of the L1D read port
`define LSU_DATA_B 8

// Destination register tag
`define LSU_TAG_W 6

`endif

//--- design/lsu_access_pkg.sv
// --------------------------------------
// Load request types
// Access size, sign mode, address, tag
// --------------------------------------

`include "lsu_load_cfg.svh"

package lsu_access_pkg;

  // Access size, encoded as log2 of bytes
  typedef enum logic [1:0] {
    SIZE_B  = 2'd0,
    SIZE_H  = 2'd1,
    SIZE_W  = 2'd2,
    SIZE_DW = 2'd3
  } size_t;

  // Extension mode of the loaded value
  typedef enum logic {
    SIGN_U = 1'b0,
    SIGN_S = 1'b1
  } sign_t;

  // Load address
  typedef logic [`LSU_VADDR_W-1:0] vaddr_t;

  // Destination register tag
  typedef logic [`LSU_TAG_W-1:0] ld_tag_t;

endpackage

//--- design/lsu_data_pkg.sv
// --------------------------------------
// Load data path types
// Doubleword, byte, byte mask, offset
// --------------------------------------

`include "lsu_load_cfg.svh"

package lsu_data_pkg;

  localparam int DATA_W     = `LSU_DATA_B * 8;
  localparam int BYTE_OFF_W = $clog2(`LSU_DATA_B);

  // One doubleword in lane order
  typedef logic [DATA_W-1:0] data_t;

  typedef logic [7:0] byte_t;

  // One bit per byte lane
  typedef logic [`LSU_DATA_B-1:0] byte_mask_t;

  // Byte position inside a doubleword
  typedef logic [BYTE_OFF_W-1:0] byte_off_t;

endpackage

//--- design/lsu_addr_gen.sv
// --------------------------------------
// Load pipe front end
// EX1/EX2 registers, address add,
// misalign check and L1D read request
// --------------------------------------

`timescale 1ns/1ps
`include "lsu_load_cfg.svh"

module lsu_addr_gen (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic                    i_issue_valid,
  input  lsu_access_pkg::ld_tag_t i_issue_tag,
  input  lsu_access_pkg::vaddr_t  i_issue_base,
  input  lsu_access_pkg::vaddr_t  i_issue_offset,
  input  lsu_access_pkg::size_t   i_issue_size,
  input  lsu_access_pkg::sign_t   i_issue_sign,
  output logic                    o_l1d_rd_valid,
  output lsu_access_pkg::vaddr_t  o_l1d_rd_addr,
  output logic                    o_ex2_valid,
  output lsu_access_pkg::vaddr_t  o_ex2_addr,
  output lsu_access_pkg::size_t   o_ex2_size,
  output lsu_access_pkg::sign_t   o_ex2_sign,
  output lsu_access_pkg::ld_tag_t o_ex2_tag,
  output logic                    o_ex2_misalign
);
  import lsu_access_pkg::*;

  logic    r_ex1_valid;
  ld_tag_t r_ex1_tag;
  vaddr_t  r_ex1_base;
  vaddr_t  r_ex1_offset;
  size_t   r_ex1_size;
  sign_t   r_ex1_sign;

  vaddr_t  w_ex1_addr;
  vaddr_t  w_ex1_size_mask;
  logic    w_ex1_misalign;

  // --------------------------------------
  // EX1 stage
  // --------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_valid <= 1'b0;
    end else begin
      r_ex1_valid <= i_issue_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex1_tag    <= i_issue_tag;
    r_ex1_base   <= i_issue_base;
    r_ex1_offset <= i_issue_offset;
    r_ex1_size   <= i_issue_size;
    r_ex1_sign   <= i_issue_sign;
  end

  assign w_ex1_addr = r_ex1_base + r_ex1_offset;

  // Low address bits that must be zero for this size
  assign w_ex1_size_mask = (vaddr_t'(1) << r_ex1_size) - vaddr_t'(1);
  assign w_ex1_misalign  = |(w_ex1_addr & w_ex1_size_mask);

  // Doubleword read, skipped for misaligned loads
  assign o_l1d_rd_valid = r_ex1_valid & ~w_ex1_misalign;
  assign o_l1d_rd_addr  = w_ex1_addr & ~vaddr_t'(`LSU_DATA_B - 1);

  // --------------------------------------
  // EX2 stage
  // --------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_ex2_valid <= 1'b0;
    end else begin
      o_ex2_valid <= r_ex1_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    o_ex2_addr     <= w_ex1_addr;
    o_ex2_size     <= r_ex1_size;
    o_ex2_sign     <= r_ex1_sign;
    o_ex2_tag      <= r_ex1_tag;
    o_ex2_misalign <= w_ex1_misalign;
  end

  // A cache read only goes out for a load aligned to its size
  a_no_misaligned_read : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_l1d_rd_valid |-> ((r_ex1_size == SIZE_B)
                     || (r_ex1_size == SIZE_H && w_ex1_addr[0] == 1'b0)
                     || (r_ex1_size == SIZE_W && w_ex1_addr[1:0] == 2'b00)
                     || (w_ex1_addr[2:0] == 3'b000)));

endmodule

//--- design/load_fwd_align.sv
// --------------------------------------
// EX2 forward request and alignment
// Shifts forward and L1D data to the
// load's first byte, builds the mask
// of bytes the size needs
// --------------------------------------

`timescale 1ns/1ps

module load_fwd_align (
  input  logic                       i_ex2_valid,
  input  lsu_access_pkg::vaddr_t     i_ex2_addr,
  input  lsu_access_pkg::size_t      i_ex2_size,
  input  logic                       i_ex2_misalign,
  input  lsu_data_pkg::data_t        i_l1d_data,
  input  lsu_data_pkg::byte_mask_t   i_stq_fwd_dw,
  input  lsu_data_pkg::data_t        i_stq_fwd_data,
  input  lsu_data_pkg::byte_mask_t   i_stbuf_fwd_dw,
  input  lsu_data_pkg::data_t        i_stbuf_fwd_data,
  output logic                       o_fwd_valid,
  output lsu_access_pkg::vaddr_t     o_fwd_addr,
  output lsu_data_pkg::byte_mask_t   o_stq_dw,
  output lsu_data_pkg::data_t        o_stq_data,
  output lsu_data_pkg::byte_mask_t   o_stbuf_dw,
  output lsu_data_pkg::data_t        o_stbuf_data,
  output lsu_data_pkg::data_t        o_l1d_aligned,
  output lsu_data_pkg::byte_mask_t   o_expected_dw
);
  import lsu_access_pkg::*;
  import lsu_data_pkg::*;

  byte_off_t               w_off;
  logic [BYTE_OFF_W+2:0]   w_bit_shift;

  assign w_off       = i_ex2_addr[BYTE_OFF_W-1:0];
  assign w_bit_shift = {w_off, 3'b000};

  // Store queue and store buffer lookup
  // by doubleword address
  assign o_fwd_valid = i_ex2_valid & ~i_ex2_misalign;
  assign o_fwd_addr  = {i_ex2_addr[$bits(vaddr_t)-1:BYTE_OFF_W], {BYTE_OFF_W{1'b0}}};

  // --------------------------------------
  // Move every source down so that lane 0
  // holds the load's first byte
  // --------------------------------------
  assign o_stq_dw      = i_stq_fwd_dw >> w_off;
  assign o_stq_data    = i_stq_fwd_data >> w_bit_shift;
  assign o_stbuf_dw    = i_stbuf_fwd_dw >> w_off;
  assign o_stbuf_data  = i_stbuf_fwd_data >> w_bit_shift;
  assign o_l1d_aligned = i_l1d_data >> w_bit_shift;

  // Low bytes the access covers
  always_comb begin
    case (i_ex2_size)
      SIZE_B  : o_expected_dw = byte_mask_t'(8'h01);
      SIZE_H  : o_expected_dw = byte_mask_t'(8'h03);
      SIZE_W  : o_expected_dw = byte_mask_t'(8'h0f);
      SIZE_DW : o_expected_dw = '1;
      default : o_expected_dw = '0;
    endcase
  end

endmodule

//--- design/load_byte_lane.sv
// --------------------------------------
// One byte lane of the load merge
// STQ over store buffer over L1D
// --------------------------------------

`timescale 1ns/1ps

module load_byte_lane (
  input  logic                i_stq_hit,
  input  lsu_data_pkg::byte_t i_stq_byte,
  input  logic                i_stbuf_hit,
  input  lsu_data_pkg::byte_t i_stbuf_byte,
  input  logic                i_l1d_hit,
  input  lsu_data_pkg::byte_t i_l1d_byte,
  output lsu_data_pkg::byte_t o_byte,
  output logic                o_covered
);
  import lsu_data_pkg::*;

  logic  w_fwd_hit;
  byte_t w_fwd_byte;

  // Younger store data in the queue wins
  assign w_fwd_hit  = i_stq_hit | i_stbuf_hit;
  assign w_fwd_byte = i_stq_hit ? i_stq_byte : i_stbuf_byte;

  // Cache byte only counts on a hit
  always_comb begin
    if (w_fwd_hit) begin
      o_byte = w_fwd_byte;
    end else if (i_l1d_hit) begin
      o_byte = i_l1d_byte;
    end else begin
      o_byte = '0;
    end
  end

  assign o_covered = w_fwd_hit | i_l1d_hit;

endmodule

//--- design/load_data_extend.sv
// --------------------------------------
// Load result stage
// Byte assembly, success check, size
// extension and EX3 result registers
// --------------------------------------

`timescale 1ns/1ps

module load_data_extend (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic                     i_ex2_valid,
  input  lsu_access_pkg::ld_tag_t  i_ex2_tag,
  input  lsu_access_pkg::vaddr_t   i_ex2_addr,
  input  lsu_access_pkg::size_t    i_ex2_size,
  input  lsu_access_pkg::sign_t    i_ex2_sign,
  input  logic                     i_ex2_misalign,
  input  lsu_data_pkg::data_t      i_lane_data,
  input  lsu_data_pkg::byte_mask_t i_lane_covered,
  input  lsu_data_pkg::byte_mask_t i_expected_dw,
  output logic                     o_wb_valid,
  output lsu_access_pkg::ld_tag_t  o_wb_tag,
  output lsu_data_pkg::data_t      o_wb_data,
  output logic                     o_replay_valid,
  output lsu_access_pkg::ld_tag_t  o_replay_tag,
  output logic                     o_except_valid,
  output lsu_access_pkg::ld_tag_t  o_except_tag,
  output lsu_access_pkg::vaddr_t   o_except_addr
);
  import lsu_access_pkg::*;
  import lsu_data_pkg::*;

  logic    w_success;
  logic    w_signed;
  data_t   w_ext_data;

  ld_tag_t r_ex3_tag;
  vaddr_t  r_ex3_addr;
  data_t   r_ex3_data;

  // Bytes outside the access never block it
  assign w_success = &(i_lane_covered | ~i_expected_dw);
  assign w_signed  = (i_ex2_sign == SIGN_S);

  // --------------------------------------
  // Extension by size
  // --------------------------------------
  always_comb begin
    case (i_ex2_size)
      SIZE_B  : w_ext_data = {{(DATA_W-8){w_signed & i_lane_data[7]}}, i_lane_data[7:0]};
      SIZE_H  : w_ext_data = {{(DATA_W-16){w_signed & i_lane_data[15]}}, i_lane_data[15:0]};
      SIZE_W  : w_ext_data = {{(DATA_W-32){w_signed & i_lane_data[31]}}, i_lane_data[31:0]};
      default : w_ext_data = i_lane_data;
    endcase
  end

  // --------------------------------------
  // EX3 registers
  // --------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_wb_valid     <= 1'b0;
      o_replay_valid <= 1'b0;
      o_except_valid <= 1'b0;
    end else begin
      o_wb_valid     <= i_ex2_valid & ~i_ex2_misalign & w_success;
      o_replay_valid <= i_ex2_valid & ~i_ex2_misalign & ~w_success;
      o_except_valid <= i_ex2_valid & i_ex2_misalign;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex3_tag  <= i_ex2_tag;
    r_ex3_addr <= i_ex2_addr;
    r_ex3_data <= w_ext_data;
  end

  // One tag register serves all three reports
  assign o_wb_tag      = r_ex3_tag;
  assign o_wb_data     = r_ex3_data;
  assign o_replay_tag  = r_ex3_tag;
  assign o_except_tag  = r_ex3_tag;
  assign o_except_addr = r_ex3_addr;

  // Success check needs exactly the low bytes of the access size
  a_expected_low_bytes : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_ex2_valid |-> (i_expected_dw == byte_mask_t'((1 << (1 << i_ex2_size)) - 1)));

endmodule

//--- design/lsu_load_pipe.sv
// --------------------------------------
// Three-stage load pipe top level
// Address stage, forward alignment,
// byte lanes and result stage
// --------------------------------------

`timescale 1ns/1ps
`include "lsu_load_cfg.svh"

module lsu_load_pipe (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  // Issue
  input  logic                     i_issue_valid,
  input  lsu_access_pkg::ld_tag_t  i_issue_tag,
  input  lsu_access_pkg::vaddr_t   i_issue_base,
  input  lsu_access_pkg::vaddr_t   i_issue_offset,
  input  lsu_access_pkg::size_t    i_issue_size,
  input  lsu_access_pkg::sign_t    i_issue_sign,
  // L1D read
  output logic                     o_l1d_rd_valid,
  output lsu_access_pkg::vaddr_t   o_l1d_rd_addr,
  input  logic                     i_l1d_hit,
  input  lsu_data_pkg::data_t      i_l1d_data,
  // Store forwarding
  output logic                     o_fwd_valid,
  output lsu_access_pkg::vaddr_t   o_fwd_addr,
  input  lsu_data_pkg::byte_mask_t i_stq_fwd_dw,
  input  lsu_data_pkg::data_t      i_stq_fwd_data,
  input  lsu_data_pkg::byte_mask_t i_stbuf_fwd_dw,
  input  lsu_data_pkg::data_t      i_stbuf_fwd_data,
  // Results
  output logic                     o_wb_valid,
  output lsu_access_pkg::ld_tag_t  o_wb_tag,
  output lsu_data_pkg::data_t      o_wb_data,
  output logic                     o_replay_valid,
  output lsu_access_pkg::ld_tag_t  o_replay_tag,
  output logic                     o_except_valid,
  output lsu_access_pkg::ld_tag_t  o_except_tag,
  output lsu_access_pkg::vaddr_t   o_except_addr
);

  logic                     w_ex2_valid;
  lsu_access_pkg::vaddr_t   w_ex2_addr;
  lsu_access_pkg::size_t    w_ex2_size;
  lsu_access_pkg::sign_t    w_ex2_sign;
  lsu_access_pkg::ld_tag_t  w_ex2_tag;
  logic                     w_ex2_misalign;

  lsu_data_pkg::byte_mask_t w_stq_dw;
  lsu_data_pkg::data_t      w_stq_data;
  lsu_data_pkg::byte_mask_t w_stbuf_dw;
  lsu_data_pkg::data_t      w_stbuf_data;
  lsu_data_pkg::data_t      w_l1d_aligned;
  lsu_data_pkg::byte_mask_t w_expected_dw;

  lsu_data_pkg::data_t      w_lane_data;
  lsu_data_pkg::byte_mask_t w_lane_covered;

  lsu_addr_gen u_addr_gen (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_issue_valid  (i_issue_valid),
    .i_issue_tag    (i_issue_tag),
    .i_issue_base   (i_issue_base),
    .i_issue_offset (i_issue_offset),
    .i_issue_size   (i_issue_size),
    .i_issue_sign   (i_issue_sign),
    .o_l1d_rd_valid (o_l1d_rd_valid),
    .o_l1d_rd_addr  (o_l1d_rd_addr),
    .o_ex2_valid    (w_ex2_valid),
    .o_ex2_addr     (w_ex2_addr),
    .o_ex2_size     (w_ex2_size),
    .o_ex2_sign     (w_ex2_sign),
    .o_ex2_tag      (w_ex2_tag),
    .o_ex2_misalign (w_ex2_misalign)
  );

  load_fwd_align u_fwd_align (
    .i_ex2_valid      (w_ex2_valid),
    .i_ex2_addr       (w_ex2_addr),
    .i_ex2_size       (w_ex2_size),
    .i_ex2_misalign   (w_ex2_misalign),
    .i_l1d_data       (i_l1d_data),
    .i_stq_fwd_dw     (i_stq_fwd_dw),
    .i_stq_fwd_data   (i_stq_fwd_data),
    .i_stbuf_fwd_dw   (i_stbuf_fwd_dw),
    .i_stbuf_fwd_data (i_stbuf_fwd_data),
    .o_fwd_valid      (o_fwd_valid),
    .o_fwd_addr       (o_fwd_addr),
    .o_stq_dw         (w_stq_dw),
    .o_stq_data       (w_stq_data),
    .o_stbuf_dw       (w_stbuf_dw),
    .o_stbuf_data     (w_stbuf_data),
    .o_l1d_aligned    (w_l1d_aligned),
    .o_expected_dw    (w_expected_dw)
  );

  // Per-byte merge, lane 0 is the load's first byte
  for (genvar b_idx = 0; b_idx < `LSU_DATA_B; b_idx++) begin : g_lane
    load_byte_lane u_lane (
      .i_stq_hit    (w_stq_dw[b_idx]),
      .i_stq_byte   (w_stq_data[b_idx*8 +: 8]),
      .i_stbuf_hit  (w_stbuf_dw[b_idx]),
      .i_stbuf_byte (w_stbuf_data[b_idx*8 +: 8]),
      .i_l1d_hit    (i_l1d_hit),
      .i_l1d_byte   (w_l1d_aligned[b_idx*8 +: 8]),
      .o_byte       (w_lane_data[b_idx*8 +: 8]),
      .o_covered    (w_lane_covered[b_idx])
    );
  end

  load_data_extend u_extend (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_ex2_valid    (w_ex2_valid),
    .i_ex2_tag      (w_ex2_tag),
    .i_ex2_addr     (w_ex2_addr),
    .i_ex2_size     (w_ex2_size),
    .i_ex2_sign     (w_ex2_sign),
    .i_ex2_misalign (w_ex2_misalign),
    .i_lane_data    (w_lane_data),
    .i_lane_covered (w_lane_covered),
    .i_expected_dw  (w_expected_dw),
    .o_wb_valid     (o_wb_valid),
    .o_wb_tag       (o_wb_tag),
    .o_wb_data      (o_wb_data),
    .o_replay_valid (o_replay_valid),
    .o_replay_tag   (o_replay_tag),
    .o_except_valid (o_except_valid),
    .o_except_tag   (o_except_tag),
    .o_except_addr  (o_except_addr)
  );

endmodule

//--- sim/tb_lsu_load_pipe.sv
// --------------------------------------
// Testbench for the load pipe
// Clock, reset, directed and random
// loads, memory and forward model,
// result checks and watchdog
// --------------------------------------

`timescale 1ns/1ps
`include "lsu_load_cfg.svh"

module tb_lsu_load_pipe;
  import lsu_access_pkg::*;
  import lsu_data_pkg::*;

  localparam int N_DIRECTED  = 11;
  localparam int N_RANDOM    = 400;
  localparam int N_TOTAL     = N_DIRECTED + N_RANDOM;
  localparam int CLK_NS      = 4;
  localparam int KIND_WB     = 0;
  localparam int KIND_REPLAY = 1;
  localparam int KIND_EXCEPT = 2;

  logic       i_clk;
  logic       i_reset_n;
  logic       i_issue_valid;
  ld_tag_t    i_issue_tag;
  vaddr_t     i_issue_base;
  vaddr_t     i_issue_offset;
  size_t      i_issue_size;
  sign_t      i_issue_sign;
  logic       i_l1d_hit;
  data_t      i_l1d_data;
  byte_mask_t i_stq_fwd_dw;
  data_t      i_stq_fwd_data;
  byte_mask_t i_stbuf_fwd_dw;
  data_t      i_stbuf_fwd_data;

  logic       o_l1d_rd_valid;
  vaddr_t     o_l1d_rd_addr;
  logic       o_fwd_valid;
  vaddr_t     o_fwd_addr;
  logic       o_wb_valid;
  ld_tag_t    o_wb_tag;
  data_t      o_wb_data;
  logic       o_replay_valid;
  ld_tag_t    o_replay_tag;
  logic       o_except_valid;
  ld_tag_t    o_except_tag;
  vaddr_t     o_except_addr;

  // Load table, one entry per issue slot
  ld_tag_t    ld_tag        [N_TOTAL];
  vaddr_t     ld_base       [N_TOTAL];
  vaddr_t     ld_offset     [N_TOTAL];
  size_t      ld_size       [N_TOTAL];
  sign_t      ld_sign       [N_TOTAL];
  logic       ld_hit        [N_TOTAL];
  byte_mask_t ld_stq_dw     [N_TOTAL];
  data_t      ld_stq_data   [N_TOTAL];
  byte_mask_t ld_stbuf_dw   [N_TOTAL];
  data_t      ld_stbuf_data [N_TOTAL];
  data_t      mem           [16];

  logic [31:0] rng_state;
  int          checks;
  int          errors;

  lsu_load_pipe dut0 (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic int size_bytes(input size_t size);
    case (size)
      SIZE_B  : return 1;
      SIZE_H  : return 2;
      SIZE_W  : return 4;
      default : return 8;
    endcase
  endfunction

  function automatic logic in_range(input int idx);
    return (idx >= 0) && (idx < N_TOTAL);
  endfunction

  function automatic vaddr_t load_addr(input int idx);
    return ld_base[idx] + ld_offset[idx];
  endfunction

  function automatic vaddr_t dw_base(input vaddr_t a);
    return {a[`LSU_VADDR_W-1:3], 3'b000};
  endfunction

  function automatic logic misaligned(input int idx);
    vaddr_t a;
    a = load_addr(idx);
    return (int'(a[2:0]) % size_bytes(ld_size[idx])) != 0;
  endfunction

  task automatic check_value(input string what, input data_t got, input data_t exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic set_load(input int idx, input vaddr_t base, input vaddr_t offset,
                          input size_t size, input sign_t sign, input logic hit,
                          input byte_mask_t stq_dw, input byte_mask_t stbuf_dw);
    ld_tag[idx]        = ld_tag_t'(idx);
    ld_base[idx]       = base;
    ld_offset[idx]     = offset;
    ld_size[idx]       = size;
    ld_sign[idx]       = sign;
    ld_hit[idx]        = hit;
    ld_stq_dw[idx]     = stq_dw;
    ld_stbuf_dw[idx]   = stbuf_dw;
    ld_stq_data[idx]   = {next_random(), next_random()};
    ld_stbuf_data[idx] = {next_random(), next_random()};
  endtask

  task automatic make_random_load(input int idx);
    logic [31:0] r;
    logic [31:0] m;
    vaddr_t      base;
    vaddr_t      offset;
    vaddr_t      low;
    r      = next_random();
    m      = next_random();
    base   = next_random();
    offset = {{20{m[31]}}, m[31:20]};
    // Three in four loads are aligned
    if (r[4:3] != 2'b00) begin
      low    = vaddr_t'(size_bytes(size_t'(r[1:0])) - 1);
      base   = base & ~low;
      offset = offset & ~low;
    end
    set_load(idx, base, offset, size_t'(r[1:0]), sign_t'(r[2]), r[7:5] != 3'b000,
             m[7:0] & m[15:8], m[19:12] & r[15:8]);
  endtask

  // --------------------------------------
  // Reference model of one load
  // --------------------------------------
  task automatic model_load(input int idx, output int kind, output data_t value);
    vaddr_t a;
    data_t  dw;
    byte_t  b;
    int     nbytes;
    int     lane;
    logic   all_covered;
    a           = load_addr(idx);
    dw          = mem[a[6:3]];
    nbytes      = size_bytes(ld_size[idx]);
    value       = '0;
    all_covered = 1'b1;
    if (misaligned(idx)) begin
      kind = KIND_EXCEPT;
    end else begin
      for (int i = 0; i < nbytes; i++) begin
        lane = int'(a[2:0]) + i;
        if (|(ld_stq_dw[idx] & (byte_mask_t'(1) << lane))) begin
          b = byte_t'(ld_stq_data[idx] >> (8 * lane));
        end else if (|(ld_stbuf_dw[idx] & (byte_mask_t'(1) << lane))) begin
          b = byte_t'(ld_stbuf_data[idx] >> (8 * lane));
        end else if (ld_hit[idx]) begin
          b = byte_t'(dw >> (8 * lane));
        end else begin
          b           = 8'h00;
          all_covered = 1'b0;
        end
        value = value | (data_t'(b) << (8 * i));
      end
      // Fill the upper bytes when the top loaded bit is set
      if (ld_sign[idx] == SIGN_S && |(value & (data_t'(1) << (8 * nbytes - 1)))) begin
        value = value | (~data_t'(0) << (8 * nbytes));
      end
      kind = all_covered ? KIND_WB : KIND_REPLAY;
    end
  endtask

  task automatic check_result(input int idx);
    int    kind;
    data_t value;
    kind  = -1;
    value = '0;
    if (in_range(idx)) begin
      model_load(idx, kind, value);
    end
    check_value("wb valid", data_t'(o_wb_valid), data_t'(kind == KIND_WB));
    check_value("replay valid", data_t'(o_replay_valid), data_t'(kind == KIND_REPLAY));
    check_value("except valid", data_t'(o_except_valid), data_t'(kind == KIND_EXCEPT));
    if (kind == KIND_WB) begin
      check_value("wb tag", data_t'(o_wb_tag), data_t'(ld_tag[idx]));
      check_value("wb data", o_wb_data, value);
    end else if (kind == KIND_REPLAY) begin
      check_value("replay tag", data_t'(o_replay_tag), data_t'(ld_tag[idx]));
    end else if (kind == KIND_EXCEPT) begin
      check_value("except tag", data_t'(o_except_tag), data_t'(ld_tag[idx]));
      check_value("except addr", data_t'(o_except_addr), data_t'(load_addr(idx)));
    end
  endtask

  // Cache request of the EX1 load, forward request of the EX2 load
  task automatic check_requests(input int c);
    logic ex1_rd;
    logic ex2_fwd;
    ex1_rd  = in_range(c - 1) && !misaligned(c - 1);
    ex2_fwd = in_range(c - 2) && !misaligned(c - 2);
    check_value("l1d read valid", data_t'(o_l1d_rd_valid), data_t'(ex1_rd));
    check_value("fwd valid", data_t'(o_fwd_valid), data_t'(ex2_fwd));
    if (ex1_rd) begin
      check_value("l1d read addr", data_t'(o_l1d_rd_addr), data_t'(dw_base(load_addr(c - 1))));
    end
    if (ex2_fwd) begin
      check_value("fwd addr", data_t'(o_fwd_addr), data_t'(dw_base(load_addr(c - 2))));
    end
  endtask

  task automatic drive_cycle(input int c);
    vaddr_t a;
    i_issue_valid = in_range(c);
    if (in_range(c)) begin
      i_issue_tag    = ld_tag[c];
      i_issue_base   = ld_base[c];
      i_issue_offset = ld_offset[c];
      i_issue_size   = ld_size[c];
      i_issue_sign   = ld_sign[c];
    end
    i_l1d_hit        = 1'b0;
    i_stq_fwd_dw     = '0;
    i_stbuf_fwd_dw   = '0;
    // Cache and forward answers for the load now in EX2
    if (in_range(c - 2)) begin
      a                = load_addr(c - 2);
      i_l1d_hit        = ld_hit[c - 2];
      i_l1d_data       = mem[a[6:3]];
      i_stq_fwd_dw     = ld_stq_dw[c - 2];
      i_stq_fwd_data   = ld_stq_data[c - 2];
      i_stbuf_fwd_dw   = ld_stbuf_dw[c - 2];
      i_stbuf_fwd_data = ld_stbuf_data[c - 2];
    end
  endtask

  initial begin
    i_clk = 1'b0;
    forever #(CLK_NS / 2) i_clk = ~i_clk;
  end

  initial begin
    #((N_TOTAL + 40) * CLK_NS);
    $display("Watchdog expired before the load sequence finished");
    $display("Some tests failed");
    $finish;
  end

  initial begin
    i_reset_n        = 1'b0;
    i_issue_valid    = 1'b0;
    i_issue_tag      = '0;
    i_issue_base     = '0;
    i_issue_offset   = '0;
    i_issue_size     = SIZE_B;
    i_issue_sign     = SIGN_U;
    i_l1d_hit        = 1'b0;
    i_l1d_data       = '0;
    i_stq_fwd_dw     = '0;
    i_stq_fwd_data   = '0;
    i_stbuf_fwd_dw   = '0;
    i_stbuf_fwd_data = '0;
    checks           = 0;
    errors           = 0;
    rng_state        = 32'h69d1;
    for (int i = 0; i < 16; i++) begin
      mem[i] = {next_random(), next_random()};
    end

    // --------------------------------------
    // Directed loads, then random ones
    // --------------------------------------
    set_load(0, 32'h0000_0100, 32'h0, SIZE_DW, SIGN_U, 1'b1, 8'h00, 8'h00);
    // Upper word, STQ over store buffer over cache
    set_load(1, 32'h0000_0200, 32'h4, SIZE_W, SIGN_S, 1'b1, 8'h20, 8'h30);
    // Signed then unsigned byte, half and word with the top bit set
    for (int i = 0; i < 6; i++) begin
      set_load(2 + i, 32'h0000_0300, vaddr_t'(8 - size_bytes(size_t'(i / 2))),
               size_t'(i / 2), sign_t'(i % 2 == 0), 1'b0, 8'hff, 8'h00);
      ld_stq_data[2 + i] = ld_stq_data[2 + i] | 64'h8080_8080_8080_8080;
    end
    // Half with its upper byte uncovered and no cache hit
    set_load(8, 32'h0000_0400, 32'h2, SIZE_H, SIGN_U, 1'b0, 8'h04, 8'h00);
    set_load(9, 32'h0000_0500, 32'h1, SIZE_H, SIGN_U, 1'b1, 8'h00, 8'h00);
    set_load(10, 32'h0000_1000, 32'hffff_fffe, SIZE_W, SIGN_S, 1'b1, 8'h00, 8'h00);
    for (int i = N_DIRECTED; i < N_TOTAL; i++) begin
      make_random_load(i);
    end

    // No load in any stage during reset
    for (int i = 0; i < 16; i++) begin
      @(posedge i_clk);
      #1;
      check_result(-1);
      check_requests(-1);
    end
    i_reset_n = 1'b1;

    for (int c = 0; c < N_TOTAL + 4; c++) begin
      @(posedge i_clk);
      #1;
      check_result(c - 3);
      check_requests(c);
      drive_cycle(c);
    end

    $display("Load pipe run: %0d loads, %0d checks, %0d errors", N_TOTAL, checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- lsu_load_pipe.f
+incdir+.
design/lsu_access_pkg.sv
design/lsu_data_pkg.sv
design/lsu_addr_gen.sv
design/load_fwd_align.sv
design/load_byte_lane.sv
design/load_data_extend.sv
design/lsu_load_pipe.sv
sim/tb_lsu_load_pipe.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_lsu_load_pipe
FILELIST  = lsu_load_pipe.f
OBJ_DIR   = obj_dir
PASS_MSG  = All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
